// File: sources.f
+incdir+.
rob_pkg.sv
robResetSync.sv
robCdcFifo.sv
robCtrl.sv
robCtrlDc.sv
robRam.sv
robDc.sv
robDc_chk.sv
robDc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the dual-clock ROB testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module robDc_tb -o simRob

output=$(./obj_dir/simRob)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

// File: robDc_tb.sv
// ================================================
// Dual-clock ROB testbench
// Random out-of-order responses on enqClk, in-order
// dequeue on clk, outputs checked against a model
// ================================================

`timescale 1ns/1ps
`include "rob_defs.svh"

module robDc_tb;

    import rob_pkg::*;

    localparam int N = `ROB_ENTRIES;

    // Stimulus length of each test in clk cycles
    localparam int RESET_CYCLES = 16;
    localparam int ALLOC_CYCLES = 120;
    localparam int RANDOM_CYCLES = 1200;
    localparam int FULL_CYCLES = 120;
    localparam int HEAD_CYCLES = 160;
    localparam int B2B_CYCLES = 40;
    localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + ALLOC_CYCLES + RANDOM_CYCLES
        + FULL_CYCLES + HEAD_CYCLES + B2B_CYCLES);

    logic clk;
    logic enqClk;
    logic areset_n;
    logic alloc;
    robMeta_t allocMeta;
    logic notFull;
    robIdx_t allocIdx;
    logic enqDataEn;
    robIdx_t enqDataIdx;
    robData_t enqData;
    logic deqEn;
    logic notEmpty;
    robData_t t2First;
    robMeta_t t2FirstMeta;

    // ================================================
    // Reference model state
    // ================================================

    // Outstanding entries in allocation order
    int orderIdx [$];
    robMeta_t orderMeta [$];
    // Allocated but not yet written
    int pending [$];
    robData_t expData [N];
    int modelAllocIdx;
    int allocCount;
    int deqCount;
    int stepNo;
    int cycleCount;
    int checkCount;
    int errorCount;
    int checkBase;
    int errorBase;
    // Responder mode: 0 idle, 1 any, 2 all but target, 3 target only
    int respMode;
    int respTarget;
    int respRate;
    bit modelActive;
    // DUT outputs as seen at the last falling clk edge
    logic sNotEmpty;
    logic sNotFull;
    robIdx_t sAllocIdx;
    // Expected outputs, one slot per clk edge after a dequeue
    logic pipeValid [2];
    robData_t pipeData [2];
    robMeta_t pipeMeta [2];

    robDc robDc_inst (.*);

    always #2 clk = ~clk;
    always #3 enqClk = ~enqClk;

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run stopped after %0d clk cycles", cycleCount);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            errorCount++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic int findPending(input int idx);
        foreach (pending[i])
            if (pending[i] == idx)
                return i;
        return -1;
    endfunction

    // Outputs are stable mid-cycle
    always @(negedge clk)
    begin
        sNotEmpty = notEmpty;
        sNotFull = notFull;
        sAllocIdx = allocIdx;
        if (modelActive)
        begin
            checkValue("notFull", 32'(notFull), (orderIdx.size() < N) ? 32'd1 : 32'd0);
            if (pipeValid[1])
            begin
                checkValue("t2First", 32'(t2First), 32'(pipeData[1]));
                checkValue("t2FirstMeta", 32'(t2FirstMeta), 32'(pipeMeta[1]));
            end
        end
    end

    // Responder, writes any allocated entry in random order
    always @(posedge enqClk)
    begin : responder
        int k;
        robData_t d;
        k = -1;
        if (!areset_n && respMode != 0 && pending.size() > 0 && ($urandom % 100) < respRate)
        begin
            if (respMode == 3)
                k = findPending(respTarget);
            else
                k = $urandom % pending.size();
            if (respMode == 2 && pending[k] == respTarget)
                k = -1;
        end
        if (k >= 0)
        begin
            // Low bits carry the index, the rest is random
            d = $urandom;
            d[$bits(robIdx_t)-1:0] = robIdx_t'(pending[k]);
            expData[pending[k]] = d;
            enqDataEn <= 1'b1;
            enqDataIdx <= robIdx_t'(pending[k]);
            enqData <= d;
            pending.delete(k);
        end
        else
            enqDataEn <= 1'b0;
    end

    // ================================================
    // One clk edge, model update then next drive
    // ================================================

    task automatic stepClk(input bit reqAlloc, input bit reqDeq);
        bit fired;
        @(posedge clk);
        stepNo++;
        fired = deqEn && sNotEmpty;
        pipeValid[1] = pipeValid[0];
        pipeData[1] = pipeData[0];
        pipeMeta[1] = pipeMeta[0];
        pipeValid[0] = fired;
        if (fired)
        begin
            pipeData[0] = expData[orderIdx[0]];
            pipeMeta[0] = orderMeta[0];
            orderIdx.delete(0);
            orderMeta.delete(0);
            deqCount++;
        end
        if (alloc)
        begin
            // Index must follow the previous allocation
            checkValue("allocIdx", 32'(sAllocIdx), 32'(modelAllocIdx));
            orderIdx.push_back(modelAllocIdx);
            orderMeta.push_back(allocMeta);
            pending.push_back(modelAllocIdx);
            modelAllocIdx = (modelAllocIdx + 1) % N;
            allocCount++;
        end
        alloc <= reqAlloc && (orderIdx.size() < N);
        allocMeta <= robMeta_t'($urandom);
        // Raise only on a head that stays filled across this edge
        deqEn <= reqDeq && (deqEn || (sNotEmpty && !fired));
    endtask

    task automatic drainRob();
        respMode = 1;
        while (orderIdx.size() > 0)
            stepClk(1'b0, 1'b1);
        repeat (3)
            stepClk(1'b0, 1'b0);
    endtask

    task automatic allocUntilFull();
        while (orderIdx.size() < N)
            stepClk(1'b1, 1'b0);
        stepClk(1'b0, 1'b0);
    endtask

    task automatic reportTest(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 checkCount - checkBase, errorCount - errorBase);
        checkBase = checkCount;
        errorBase = errorCount;
    endtask

    // ================================================
    // Tests
    // ================================================

    task automatic resetState();
        stepClk(1'b0, 1'b0);
        stepClk(1'b0, 1'b0);
        checkValue("notEmpty", 32'(sNotEmpty), 0);
        checkValue("notFull", 32'(sNotFull), 1);
        checkValue("allocIdx", 32'(sAllocIdx), 0);
        reportTest("reset state");
    endtask

    task automatic allocSequence();
        int start;
        start = allocCount;
        respMode = 1;
        while (allocCount - start < 40)
            stepClk(1'b1, 1'b1);
        drainRob();
        reportTest("allocation index");
    endtask

    task automatic randomReorder();
        int start;
        start = allocCount;
        respMode = 1;
        respRate = 70;
        while (allocCount - start < 200)
            stepClk(($urandom % 4) != 0, ($urandom % 3) != 0);
        drainRob();
        respRate = 100;
        reportTest("random reorder");
    endtask

    task automatic fullFlag();
        int base;
        respMode = 0;
        allocUntilFull();
        checkValue("notFull", 32'(sNotFull), 0);
        // Fill only the oldest, then free it
        respTarget = orderIdx[0];
        respMode = 3;
        while (!sNotEmpty)
            stepClk(1'b0, 1'b0);
        base = deqCount;
        while (deqCount == base)
            stepClk(1'b0, 1'b1);
        stepClk(1'b0, 1'b0);
        checkValue("notFull", 32'(sNotFull), 1);
        drainRob();
        reportTest("full flag");
    endtask

    task automatic headBlocking();
        respMode = 0;
        allocUntilFull();
        respTarget = orderIdx[0];
        respMode = 2;
        while (pending.size() > 1)
            stepClk(1'b0, 1'b0);
        repeat (50)
        begin
            stepClk(1'b0, 1'b0);
            checkValue("notEmpty", 32'(sNotEmpty), 0);
        end
        respMode = 1;
        while (!sNotEmpty)
            stepClk(1'b0, 1'b0);
        reportTest("head blocking");
    endtask

    // Oldest was written last, so every entry is filled here
    task automatic backToBack();
        int base;
        int first;
        base = deqCount;
        first = -1;
        while (deqCount - base < N)
        begin
            stepClk(1'b0, 1'b1);
            if (deqCount - base == 1 && first < 0)
                first = stepNo;
        end
        checkValue("dequeue span", stepNo - first, N - 1);
        repeat (3)
            stepClk(1'b0, 1'b0);
        reportTest("back-to-back dequeue");
    endtask

    initial
    begin
        void'($urandom(4));
        clk = 1'b0;
        enqClk = 1'b0;
        areset_n = 1'b1;
        alloc = 1'b0;
        allocMeta = '0;
        enqDataEn = 1'b0;
        enqDataIdx = '0;
        enqData = '0;
        deqEn = 1'b0;
        respRate = 100;
        pipeValid[0] = 1'b0;
        pipeValid[1] = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        areset_n <= 1'b0;
        modelActive = 1'b1;
        resetState();
        allocSequence();
        randomReorder();
        fullFlag();
        headBlocking();
        backToBack();
        $display("total: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: robDc_chk.sv
// ================================================
// ROB protocol checker
// Bound into the dual-clock controller, watches the
// requester, consumer and index FIFO write side
// ================================================

`timescale 1ns/1ps

module robDc_chk
(
    input logic clk,
    input logic areset_n,
    input logic alloc,
    input logic notFull,
    input logic deqEn,
    input logic notEmpty,
    input logic enqClk,
    input logic enqReset,
    input logic enqDataEn,
    input logic enqNotFull
);

    // FIFO is as deep as the ROB, a response never meets a full FIFO
    fifoNoOverflow: assert property (@(posedge enqClk) disable iff (enqReset)
        enqDataEn |-> enqNotFull)
        else $error("index FIFO written while full");

    // Requester allocates only into a free entry
    allocWhenFree: assert property (@(posedge clk) disable iff (areset_n)
        alloc |-> notFull)
        else $error("alloc while every entry is outstanding");

    // Dequeue request starts only on a filled head
    deqRiseWhenReady: assert property (@(posedge clk) disable iff (areset_n)
        $rose(deqEn) |-> notEmpty)
        else $error("deqEn raised while the head entry is empty");

endmodule

bind robCtrlDc robDc_chk chk
(
    .clk(clk),
    .areset_n(areset_n),
    .alloc(alloc),
    .notFull(notFull),
    .deqEn(deqEn),
    .notEmpty(notEmpty),
    .enqClk(enqClk),
    .enqReset(enqReset),
    .enqDataEn(enqDataEn),
    .enqNotFull(enqNotFull)
);

// File: robDc.sv
// ================================================
// Dual-clock reorder buffer
// Allocation and ordered output on clk, responses in
// any order on enqClk, data and meta returned together
// ================================================

`timescale 1ns/1ps
`include "rob_defs.svh"

module robDc
(
    input  logic              clk,
    input  logic              areset_n,

    // Requester side
    input  logic              alloc,
    input  rob_pkg::robMeta_t allocMeta,
    output logic              notFull,
    output rob_pkg::robIdx_t  allocIdx,

    // Responder side, enqClk domain, no ready
    input  logic              enqClk,
    input  logic              enqDataEn,
    input  rob_pkg::robIdx_t  enqDataIdx,
    input  rob_pkg::robData_t enqData,

    // Consumer side, outputs two edges after the dequeue edge
    input  logic              deqEn,
    output logic              notEmpty,
    output rob_pkg::robData_t t2First,
    output rob_pkg::robMeta_t t2FirstMeta
);

    import rob_pkg::*;

    // Oldest entry, read address for both RAMs
    robIdx_t deqIdx;

    robCtrlDc ctrlDc
    (
        .clk(clk),
        .areset_n(areset_n),
        .alloc(alloc),
        .allocIdx(allocIdx),
        .notFull(notFull),
        .enqClk(enqClk),
        .enqDataEn(enqDataEn),
        .enqDataIdx(enqDataIdx),
        .deqEn(deqEn),
        .notEmpty(notEmpty),
        .deqIdx(deqIdx)
    );

    // ================================================
    // Payload, written on enqClk and read on clk
    // ================================================

    robRam #(.ENTRIES(`ROB_ENTRIES), .WIDTH(`ROB_DATA_BITS), .REG_WRITE(1'b1)) dataRam
    (
        .wrClk(enqClk),
        .wrEn(enqDataEn),
        .wrAddr(enqDataIdx),
        .wrData(enqData),
        .rdClk(clk),
        .rdAddr(deqIdx),
        .rdData(t2First)
    );

    // Meta-data saved at allocation, single clock
    robRam #(.ENTRIES(`ROB_ENTRIES), .WIDTH(`ROB_META_BITS), .REG_WRITE(1'b0)) metaRam
    (
        .wrClk(clk),
        .wrEn(alloc),
        .wrAddr(allocIdx),
        .wrData(allocMeta),
        .rdClk(clk),
        .rdAddr(deqIdx),
        .rdData(t2FirstMeta)
    );

endmodule

// File: robRam.sv
// ================================================
// Simple dual-port RAM
// Optional write register, registered read address,
// one output register, so data follows two rdClk edges
// ================================================

`timescale 1ns/1ps

module robRam
#(
    parameter int ENTRIES   = 16,
    parameter int WIDTH     = 32,
    parameter bit REG_WRITE = 1'b0
)
(
    input  logic             wrClk,
    input  logic             wrEn,
    input  rob_pkg::robIdx_t wrAddr,
    input  logic [WIDTH-1:0] wrData,
    input  logic             rdClk,
    input  rob_pkg::robIdx_t rdAddr,
    output logic [WIDTH-1:0] rdData
);

    import rob_pkg::*;

    logic [WIDTH-1:0] mem [ENTRIES];

    // Write port after the optional register stage
    logic memWrEn;
    robIdx_t memWrAddr;
    logic [WIDTH-1:0] memWrData;

    // Read address captured at the dequeue edge
    robIdx_t rdAddrQ;

    generate
        if (REG_WRITE)
        begin : genWrReg
            // Write lands one wrClk edge later
            always_ff @(posedge wrClk)
            begin
                memWrEn <= wrEn;
                memWrAddr <= wrAddr;
                memWrData <= wrData;
            end
        end
        else
        begin : genWrDirect
            assign memWrEn = wrEn;
            assign memWrAddr = wrAddr;
            assign memWrData = wrData;
        end
    endgenerate

    always_ff @(posedge wrClk)
    begin
        if (memWrEn)
            mem[memWrAddr] <= memWrData;
    end

    // Address stage then output stage
    always_ff @(posedge rdClk)
    begin
        rdAddrQ <= rdAddr;
        rdData <= mem[rdAddrQ];
    end

endmodule

// File: robCtrlDc.sv
// ================================================
// Dual-clock ROB controller
// Response indices cross from enqClk into clk, get
// one register stage, then drive the ROB bookkeeping
// ================================================

`timescale 1ns/1ps

module robCtrlDc
(
    input  logic             clk,
    input  logic             areset_n,
    input  logic             alloc,
    output rob_pkg::robIdx_t allocIdx,
    output logic             notFull,
    input  logic             enqClk,
    input  logic             enqDataEn,
    input  rob_pkg::robIdx_t enqDataIdx,
    input  logic             deqEn,
    output logic             notEmpty,
    output rob_pkg::robIdx_t deqIdx
);

    import rob_pkg::*;

    // Reset as seen by the enqClk side of the FIFO
    logic enqReset;
    // FIFO write-side full flag, never expected low on a write
    logic enqNotFull;

    logic fifoNotEmpty;
    robIdx_t fifoIdx;

    // Popped index, one clk stage before robCtrl
    logic fillEnQ;
    robIdx_t fillIdxQ;

    robResetSync resetSync
    (
        .clk(enqClk),
        .resetIn(areset_n),
        .resetOut(enqReset)
    );

    // Depth equals ROB size, so every outstanding index fits
    robCdcFifo cdcFifo
    (
        .wrClk(enqClk),
        .wrReset(enqReset),
        .wrEn(enqDataEn),
        .wrData(enqDataIdx),
        .wrNotFull(enqNotFull),
        .rdClk(clk),
        .rdReset(areset_n),
        .rdEn(fifoNotEmpty),
        .rdData(fifoIdx),
        .rdNotEmpty(fifoNotEmpty)
    );

    // Pop every cycle the FIFO has something
    always_ff @(posedge clk)
    begin
        if (areset_n)
            fillEnQ <= 1'b0;
        else
            fillEnQ <= fifoNotEmpty;
    end

    always_ff @(posedge clk)
    begin
        fillIdxQ <= fifoIdx;
    end

    robCtrl ctrl
    (
        .clk(clk),
        .areset_n(areset_n),
        .alloc(alloc),
        .fillEn(fillEnQ),
        .fillIdx(fillIdxQ),
        .deqEn(deqEn),
        .allocIdx(allocIdx),
        .notFull(notFull),
        .notEmpty(notEmpty),
        .deqIdx(deqIdx)
    );

endmodule

// File: robCtrl.sv
// ================================================
// Single-clock ROB controller
// Allocation and oldest pointers, per-entry filled bits
// Full and empty flags for requester and consumer
// ================================================

`timescale 1ns/1ps
`include "rob_defs.svh"

module robCtrl
(
    input  logic             clk,
    input  logic             areset_n,

    // Allocation, one entry per strobe
    input  logic             alloc,

    // Fill notice, entry fillIdx now holds its data
    input  logic             fillEn,
    input  rob_pkg::robIdx_t fillIdx,

    // In-order dequeue
    input  logic             deqEn,

    output rob_pkg::robIdx_t allocIdx,
    output logic             notFull,
    output logic             notEmpty,
    output rob_pkg::robIdx_t deqIdx
);

    import rob_pkg::*;

    localparam int IDX_BITS = $bits(robIdx_t);

    // Pointers differ only in the wrap bit when every entry is outstanding
    localparam robPtr_t WRAP_ONLY = robPtr_t'(1) << IDX_BITS;

    robPtr_t allocPtr;
    robPtr_t oldestPtr;

    // One bit per entry, set by a fill and cleared by its dequeue
    logic [`ROB_ENTRIES-1:0] filled;

    logic deqFire;

    // Index handed out in the same cycle as alloc
    assign allocIdx = allocPtr[IDX_BITS-1:0];
    assign deqIdx = oldestPtr[IDX_BITS-1:0];

    assign notFull = ((allocPtr ^ oldestPtr) != WRAP_ONLY);
    // Head blocks until the oldest entry itself is filled
    assign notEmpty = filled[deqIdx];

    assign deqFire = deqEn && notEmpty;

    // ================================================
    // Pointers
    // ================================================

    always_ff @(posedge clk)
    begin
        if (areset_n)
        begin
            allocPtr <= '0;
            oldestPtr <= '0;
        end
        else
        begin
            if (alloc)
                allocPtr <= allocPtr + robPtr_t'(1);
            if (deqFire)
                oldestPtr <= oldestPtr + robPtr_t'(1);
        end
    end

    // ================================================
    // Filled bits
    // ================================================

    always_ff @(posedge clk)
    begin
        if (areset_n)
            filled <= '0;
        else
        begin
            if (fillEn)
                filled[fillIdx] <= 1'b1;
            // A fill never targets the head being dequeued
            if (deqFire)
                filled[deqIdx] <= 1'b0;
        end
    end

endmodule

// File: robCdcFifo.sv
// ================================================
// Dual-clock index FIFO
// Gray-coded pointers with one synchronizer per direction
// Show-ahead read side where rdData is valid with rdNotEmpty
// ================================================

`timescale 1ns/1ps
`include "rob_defs.svh"

module robCdcFifo
(
    // Write side
    input  logic             wrClk,
    input  logic             wrReset,
    input  logic             wrEn,
    input  rob_pkg::robIdx_t wrData,
    output logic             wrNotFull,

    // Read side
    input  logic             rdClk,
    input  logic             rdReset,
    input  logic             rdEn,
    output rob_pkg::robIdx_t rdData,
    output logic             rdNotEmpty
);

    import rob_pkg::*;

    localparam int IDX_BITS = $bits(robIdx_t);
    localparam int PTR_BITS = $bits(robPtr_t);

    // Full when the two top gray bits are inverted and the rest match
    localparam robPtr_t FULL_MASK = {2'b11, {(PTR_BITS - 2){1'b0}}};

    // Storage written on wrClk and read without a clock
    robIdx_t mem [`ROB_ENTRIES];

    // Read pointer in gray code, synchronized into the write domain
    robPtr_t rdPtrGray;

    // ================================================
    // Write domain
    // ================================================

    robPtr_t wrPtrBin;
    robPtr_t wrPtrGray;
    robPtr_t wrPtrBinNext;
    robPtr_t [`ROB_SYNC_STAGES-1:0] rdGraySync;
    logic wrPush;

    assign wrPush = wrEn && wrNotFull;
    assign wrPtrBinNext = wrPtrBin + robPtr_t'(1);

    // Compare against the last stage of the read pointer synchronizer
    assign wrNotFull = (wrPtrGray != (rdGraySync[`ROB_SYNC_STAGES-1] ^ FULL_MASK));

    always_ff @(posedge wrClk)
    begin
        if (wrReset)
        begin
            wrPtrBin <= '0;
            wrPtrGray <= '0;
            rdGraySync <= '0;
        end
        else
        begin
            rdGraySync <= {rdGraySync[`ROB_SYNC_STAGES-2:0], rdPtrGray};
            if (wrPush)
            begin
                wrPtrBin <= wrPtrBinNext;
                // Binary to gray so only one bit flips per push
                wrPtrGray <= wrPtrBinNext ^ (wrPtrBinNext >> 1);
            end
        end
    end

    // Entry written at the binary write pointer
    always_ff @(posedge wrClk)
    begin
        if (wrPush)
            mem[wrPtrBin[IDX_BITS-1:0]] <= wrData;
    end

    // ================================================
    // Read domain
    // ================================================

    robPtr_t rdPtrBin;
    robPtr_t rdPtrBinNext;
    robPtr_t [`ROB_SYNC_STAGES-1:0] wrGraySync;
    logic rdPop;

    assign rdPop = rdEn && rdNotEmpty;
    assign rdPtrBinNext = rdPtrBin + robPtr_t'(1);

    // Empty when local and synchronized remote gray pointers agree
    assign rdNotEmpty = (rdPtrGray != wrGraySync[`ROB_SYNC_STAGES-1]);

    // Head entry shown ahead of the pop
    assign rdData = mem[rdPtrBin[IDX_BITS-1:0]];

    always_ff @(posedge rdClk)
    begin
        if (rdReset)
        begin
            rdPtrBin <= '0;
            rdPtrGray <= '0;
            wrGraySync <= '0;
        end
        else
        begin
            wrGraySync <= {wrGraySync[`ROB_SYNC_STAGES-2:0], wrPtrGray};
            if (rdPop)
            begin
                rdPtrBin <= rdPtrBinNext;
                rdPtrGray <= rdPtrBinNext ^ (rdPtrBinNext >> 1);
            end
        end
    end

endmodule

// File: robResetSync.sv
// ================================================
// Reset synchronizer
// Asserts at once, releases after a flop chain
// ================================================

`timescale 1ns/1ps
`include "rob_defs.svh"

module robResetSync
(
    input  logic clk,
    input  logic resetIn,
    output logic resetOut
);

    // Shift register filled with ones while reset is held
    logic [`ROB_SYNC_STAGES-1:0] resetPipe;

    always_ff @(posedge clk)
    begin
        if (resetIn)
            resetPipe <= '1;
        else
            resetPipe <= {resetPipe[`ROB_SYNC_STAGES-2:0], 1'b0};
    end

    // Immediate assertion, release only once the chain drains
    assign resetOut = resetIn | resetPipe[`ROB_SYNC_STAGES-1];

endmodule

// File: rob_pkg.sv
// ================================================
// ROB shared types
// Index, pointer, payload and meta-data vectors
// ================================================

`include "rob_defs.svh"

package rob_pkg;

    // Entry index into the ROB and its RAMs
    typedef logic [$clog2(`ROB_ENTRIES)-1:0] robIdx_t;

    // Index plus one wrap bit
    // Used for binary and gray FIFO pointers too
    typedef logic [$clog2(`ROB_ENTRIES):0] robPtr_t;

    // Response payload word
    typedef logic [`ROB_DATA_BITS-1:0] robData_t;

    // Meta-data word saved with each allocation
    typedef logic [`ROB_META_BITS-1:0] robMeta_t;

endpackage

// File: rob_defs.svh
// ================================================
// ROB build-time constants
// Depth, payload and meta widths, synchronizer depth
// ================================================

`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Entry count, also the depth of the index crossing FIFO
`define ROB_ENTRIES 16
// Response payload width
`define ROB_DATA_BITS 32
// Meta-data stored at allocation
`define ROB_META_BITS 4
// Flops per clock-crossing synchronizer
`define ROB_SYNC_STAGES 2

`endif
